// ==== Makefile ====
# Verilator simulation of the instruction fetch stage.
# compile builds the binary, run simulates and greps the log, clean tidies up.

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
	  --top-module if_stage_tb -f if_stage.f \
	  --Mdir obj_dir -o if_stage_sim

run: compile
	./obj_dir/if_stage_sim > $(LOG) 2>&1; cat $(LOG)
	grep -qx "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/if_stage_tb.sv ====
/*
  Random testbench for the fetch stage, seed 66. Controller and bus responder
  share one process that samples and drives 1 ns after each rising edge.
  Every wait gives up after 200 cycles.
*/

`timescale 1ns/1ps
`include "if_config.svh"

module if_stage_tb;

  localparam int             RUN_CYCLES = 4000;
  localparam int             TIMEOUT    = 200;
  localparam if_pkg::instr_t DATA_KEY   = 32'h5A3C_96E1;
  localparam int             MEM_IDLE   = 0;
  localparam int             MEM_GNT    = 1;
  localparam int             MEM_RESP   = 2;

  logic                clk;
  logic                rst_n;
  // controller side
  logic                pc_set_i;
  if_pkg::pc_sel_e     pc_mux_i;
  if_pkg::exc_pc_sel_e exc_pc_mux_i;
  if_pkg::irq_id_t     exc_cause_i;
  if_pkg::addr_t       boot_addr_i;
  if_pkg::addr_t       branch_target_ex_i;
  if_pkg::addr_t       csr_mepc_i;
  if_pkg::addr_t       csr_depc_i;
  if_pkg::addr_t       csr_mtvec_i;
  logic                id_in_ready_i;
  logic                instr_valid_clear_i;
  // instruction bus
  logic                instr_req_o;
  if_pkg::addr_t       instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  if_pkg::instr_t      instr_rdata_i;
  logic                instr_err_i;
  // towards ID
  logic                instr_valid_id_o;
  logic                instr_new_id_o;
  if_pkg::instr_t      instr_rdata_id_o;
  logic                instr_fetch_err_o;
  if_pkg::addr_t       pc_id_o;
  if_pkg::addr_t       pc_if_o;
  logic                csr_mtvec_init_o;
  logic                pc_mismatch_alert_o;
  logic                if_busy_o;

  // reference model and bookkeeping
  if_pkg::addr_t exp_pc;
  logic          started;
  logic          valid_seen;
  logic          timed_out;
  int            idle_cycles;
  int            delivered;
  int            checks;
  int            addr_errors;
  int            instr_errors;
  int            bit_errors;
  int            other_errors;
  // memory responder
  int            mem_phase;
  int            mem_count;
  if_pkg::addr_t mem_addr;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  if_stage uut (
    .clk_i (clk), .rst_ni (rst_n), .boot_addr_i (boot_addr_i),
    .pc_set_i (pc_set_i), .pc_mux_i (pc_mux_i), .exc_pc_mux_i (exc_pc_mux_i),
    .exc_cause_i (exc_cause_i), .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i (csr_mepc_i), .csr_depc_i (csr_depc_i), .csr_mtvec_i (csr_mtvec_i),
    .id_in_ready_i (id_in_ready_i), .instr_valid_clear_i (instr_valid_clear_i),
    .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
    .instr_gnt_i (instr_gnt_i), .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i), .instr_err_i (instr_err_i),
    .instr_valid_id_o (instr_valid_id_o), .instr_new_id_o (instr_new_id_o),
    .instr_rdata_id_o (instr_rdata_id_o), .instr_fetch_err_o (instr_fetch_err_o),
    .pc_id_o (pc_id_o), .pc_if_o (pc_if_o), .csr_mtvec_init_o (csr_mtvec_init_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o), .if_busy_o (if_busy_o)
  );

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_addr(input string name, input if_pkg::addr_t got,
                              input if_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      addr_errors++;
    end
  endtask

  task automatic compare_instr(input string name, input if_pkg::instr_t got,
                               input if_pkg::instr_t exp);
    checks++;
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      instr_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      bit_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // redirect target from the controller inputs as driven this cycle
  function automatic if_pkg::addr_t expected_target();
    if_pkg::addr_t base;
    if_pkg::addr_t pc;
    base = csr_mtvec_i & 32'hFFFF_FF00;
    case (pc_mux_i)
      if_pkg::PC_BOOT: pc = boot_addr_i & 32'hFFFF_FF00;
      if_pkg::PC_JUMP: pc = branch_target_ex_i;
      if_pkg::PC_EXC: begin
        case (exc_pc_mux_i)
          if_pkg::EXC_PC_EXC: pc = base;
          // vectored mode, one word per interrupt
          if_pkg::EXC_PC_IRQ: pc = base + 32'(exc_cause_i) * 32'd4;
          if_pkg::EXC_PC_DBD: pc = `IF_DM_HALT_ADDR;
          default:            pc = `IF_DM_EXC_ADDR;
        endcase
      end
      if_pkg::PC_ERET: pc = csr_mepc_i;
      default:         pc = csr_depc_i;
    endcase
    return pc & 32'hFFFF_FFFC;
  endfunction

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was not released within %0d cycles", TIMEOUT);
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  // inputs still hold last cycle's values here
  task automatic check_controls();
    compare_bit("csr_mtvec_init_o", csr_mtvec_init_o,
                pc_set_i && (pc_mux_i == if_pkg::PC_BOOT));
    compare_bit("pc_mismatch_alert_o", pc_mismatch_alert_o, 1'b0);
    if (!started) begin
      compare_bit("instr_req_o", instr_req_o, 1'b0);
      compare_bit("instr_valid_id_o", instr_valid_id_o, 1'b0);
      compare_bit("if_busy_o", if_busy_o, 1'b0);
    end
    // a bus transfer is open until its response arrives
    if (mem_phase != MEM_IDLE) begin
      compare_bit("if_busy_o", if_busy_o, 1'b1);
    end
    if (instr_req_o) begin
      compare_bit("instr_addr_o word aligned", instr_addr_o[1:0] == 2'b00, 1'b1);
    end
    // valid holds until ID clears it
    if (valid_seen && !instr_valid_clear_i) begin
      compare_bit("instr_valid_id_o", instr_valid_id_o, 1'b1);
    end
    valid_seen = instr_valid_id_o;
  endtask

  task automatic check_delivery();
    if (instr_new_id_o) begin
      idle_cycles = 0;
      // pc_set_i in the accept cycle squashes the item
      if (!pc_set_i) begin
        compare_bit("instr_valid_id_o", instr_valid_id_o, 1'b1);
        compare_addr("pc_id_o", pc_id_o, exp_pc);
        compare_instr("instr_rdata_id_o", instr_rdata_id_o, exp_pc ^ DATA_KEY);
        compare_bit("instr_fetch_err_o", instr_fetch_err_o, exp_pc[11:8] == 4'h5);
        exp_pc = exp_pc + 32'd4;
        // fetch has already moved on to the next word
        compare_addr("pc_if_o", pc_if_o, exp_pc);
        compare_bit("if_busy_o", if_busy_o, 1'b1);
        delivered++;
      end
    end else if (started) begin
      idle_cycles++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // grant 0 to 2 cycles after req, rvalid 1 to 3 cycles after grant
  task automatic drive_memory();
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    if (mem_phase == MEM_RESP) begin
      if (mem_count == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = mem_addr ^ DATA_KEY;
        instr_err_i    = (mem_addr[11:8] == 4'h5);
        mem_phase      = MEM_IDLE;
      end else begin
        mem_count--;
      end
    end else if (instr_req_o) begin
      if (mem_phase == MEM_IDLE) begin
        mem_count = $urandom_range(2, 0);
        mem_phase = MEM_GNT;
      end
      if (mem_count == 0) begin
        instr_gnt_i = 1'b1;
        mem_addr    = instr_addr_o;
        mem_count   = $urandom_range(2, 0);
        mem_phase   = MEM_RESP;
      end else begin
        mem_count--;
      end
    end
  endtask

  task automatic drive_controller(input int cycle);
    logic [2:0] sel_raw;
    logic [1:0] exc_raw;
    instr_valid_clear_i = instr_valid_id_o & (($urandom % 2) == 0);
    id_in_ready_i       = ($urandom % 10) < 7;
    // first redirect is the boot jump
    pc_set_i = started ? (($urandom % 16) == 0) : (cycle == 5);
    if (pc_set_i) begin
      sel_raw            = started ? 3'($urandom_range(4, 0)) : 3'd0;
      exc_raw            = 2'($urandom);
      pc_mux_i           = if_pkg::pc_sel_e'(sel_raw);
      exc_pc_mux_i       = if_pkg::exc_pc_sel_e'(exc_raw);
      exc_cause_i        = 5'($urandom);
      boot_addr_i        = $urandom & 32'hFFFF_FF00;
      branch_target_ex_i = $urandom & 32'hFFFF_FFFC;
      csr_mepc_i         = $urandom & 32'hFFFF_FFFC;
      csr_depc_i         = $urandom & 32'hFFFF_FFFC;
      csr_mtvec_i        = $urandom;
      exp_pc             = expected_target();
      started            = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned seed_ret;
    seed_ret            = $urandom(66);
    pc_set_i            = 1'b0;
    pc_mux_i            = if_pkg::PC_BOOT;
    exc_pc_mux_i        = if_pkg::EXC_PC_EXC;
    exc_cause_i         = '0;
    boot_addr_i         = '0;
    branch_target_ex_i  = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    csr_mtvec_i         = '0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_err_i         = 1'b0;
    exp_pc              = '0;
    started             = 1'b0;
    valid_seen          = 1'b0;
    timed_out           = 1'b0;
    idle_cycles         = 0;
    delivered           = 0;
    checks              = 0;
    addr_errors         = 0;
    instr_errors        = 0;
    bit_errors          = 0;
    other_errors        = 0;
    mem_phase           = MEM_IDLE;
    mem_count           = 0;
    mem_addr            = '0;
    wait_reset_release();
    for (int cycle = 0; cycle < RUN_CYCLES && !timed_out; cycle++) begin
      @(posedge clk);
      #1;
      check_controls();
      check_delivery();
      if (idle_cycles > TIMEOUT) begin
        $display("Timeout: no instruction reached ID within %0d cycles", TIMEOUT);
        other_errors++;
        timed_out = 1'b1;
      end
      drive_memory();
      drive_controller(cycle);
    end
    if (!timed_out && delivered < 100) begin
      $display("Too few instructions reached ID: %0d", delivered);
      other_errors++;
    end
    $display("checks %0d, delivered %0d, errors: addr %0d, instr %0d, bit %0d, other %0d",
             checks, delivered, addr_errors, instr_errors, bit_errors, other_errors);
    if (addr_errors + instr_errors + bit_errors + other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
/*
  Free-running 10 ns clock. Reset is held low over the first four rising
  edges and released 1 ns after the fourth.
*/

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 5 ns half period
  initial begin
    clk_o = 1'b0;
    forever begin
      #5 clk_o = ~clk_o;
    end
  end

  // active-low reset for four cycles
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== if_stage.f ====
+incdir+logic
logic/if_pkg.sv
logic/if_pc_select.sv
logic/if_fetch_unit.sv
logic/if_id_reg.sv
logic/if_pc_check.sv
logic/if_stage.sv
bench/tb_clock_gen.sv
bench/if_stage_tb.sv

// ==== logic/if_config.svh ====
/*
  Fixed constants of the fetch stage. Only word-aligned 32-bit instructions
  are handled, so the PC always steps by four bytes.
*/

`ifndef IF_CONFIG_SVH
`define IF_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// debug module entry points
//////////////////////////////////////////////////////////////////////

// entered on a debug halt request
`define IF_DM_HALT_ADDR   32'h1A110800
// entered on an exception while in debug mode
`define IF_DM_EXC_ADDR    32'h1A110808

// low bits forced to zero in the boot address and the mtvec base
`define IF_VEC_ALIGN_BITS 8
// bytes per instruction, no compressed support
`define IF_INSTR_BYTES    4

`endif

// ==== logic/if_fetch_unit.sv ====
/*
  One request in flight at most. A redirect before the grant keeps the old
  request on the bus until granted, then its response is swallowed.
  Nothing is fetched after reset until the first pc_set_i.
*/

`timescale 1ns/1ps
`include "if_config.svh"

module if_fetch_unit (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           pc_set_i,
  input  if_pkg::addr_t  fetch_addr_n_i,
  input  logic           instr_accept_i,
  output logic           instr_req_o,
  output if_pkg::addr_t  instr_addr_o,
  input  logic           instr_gnt_i,
  input  logic           instr_rvalid_i,
  input  if_pkg::instr_t instr_rdata_i,
  input  logic           instr_err_i,
  output logic           fetch_valid_o,
  output if_pkg::instr_t fetch_rdata_o,
  output if_pkg::addr_t  fetch_addr_o,
  output logic           fetch_err_o,
  output logic           busy_o
);

  if_pkg::fetch_state_e state_q, state_d;
  // set when a redirect hits a request that is not granted yet
  logic                 stale_q, stale_d;
  logic                 load_req;
  if_pkg::addr_t        load_addr;
  // address on the bus, and of the item in the holding register
  if_pkg::addr_t        req_addr_q;
  // pending redirect target while a stale response is owed
  if_pkg::addr_t        redir_addr_q;
  if_pkg::addr_t        seq_addr;
  if_pkg::instr_t       rdata_q;
  logic                 err_q;

  assign seq_addr = req_addr_q + if_pkg::addr_t'(`IF_INSTR_BYTES);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    stale_d   = stale_q;
    load_req  = 1'b0;
    load_addr = fetch_addr_n_i;
    unique case (state_q)
      if_pkg::FETCH_IDLE: begin
        if (pc_set_i) begin
          state_d  = if_pkg::FETCH_REQ;
          load_req = 1'b1;
        end
      end
      if_pkg::FETCH_REQ: begin
        // address stays put until granted, stale or not
        if (instr_gnt_i) begin
          state_d = (pc_set_i || stale_q) ? if_pkg::FETCH_FLUSH : if_pkg::FETCH_WAIT;
          stale_d = 1'b0;
        end else if (pc_set_i) begin
          stale_d = 1'b1;
        end
      end
      if_pkg::FETCH_WAIT: begin
        if (instr_rvalid_i && pc_set_i) begin
          // response dropped right here, restart at once
          state_d  = if_pkg::FETCH_REQ;
          load_req = 1'b1;
        end else if (instr_rvalid_i) begin
          state_d = if_pkg::FETCH_HOLD;
        end else if (pc_set_i) begin
          state_d = if_pkg::FETCH_FLUSH;
        end
      end
      if_pkg::FETCH_FLUSH: begin
        if (instr_rvalid_i) begin
          state_d   = if_pkg::FETCH_REQ;
          load_req  = 1'b1;
          load_addr = pc_set_i ? fetch_addr_n_i : redir_addr_q;
        end
      end
      if_pkg::FETCH_HOLD: begin
        // redirect discards the held item, even if accepted now
        if (pc_set_i) begin
          state_d  = if_pkg::FETCH_REQ;
          load_req = 1'b1;
        end else if (instr_accept_i) begin
          state_d   = if_pkg::FETCH_REQ;
          load_req  = 1'b1;
          load_addr = seq_addr;
        end
      end
      default: state_d = if_pkg::FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= if_pkg::FETCH_IDLE;
      stale_q    <= 1'b0;
      req_addr_q <= '0;
    end else begin
      state_q <= state_d;
      stale_q <= stale_d;
      if (load_req) begin
        req_addr_q <= load_addr;
      end
    end
  end

  // response holding register and redirect target
  always_ff @(posedge clk_i) begin
    if (pc_set_i) begin
      redir_addr_q <= fetch_addr_n_i;
    end
    if (state_q == if_pkg::FETCH_WAIT && instr_rvalid_i) begin
      rdata_q <= instr_rdata_i;
      err_q   <= instr_err_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign instr_req_o   = (state_q == if_pkg::FETCH_REQ);
  assign instr_addr_o  = req_addr_q;
  assign fetch_valid_o = (state_q == if_pkg::FETCH_HOLD);
  assign fetch_rdata_o = rdata_q;
  assign fetch_addr_o  = req_addr_q;
  assign fetch_err_o   = err_q;
  assign busy_o        = (state_q == if_pkg::FETCH_REQ) ||
                         (state_q == if_pkg::FETCH_WAIT) ||
                         (state_q == if_pkg::FETCH_FLUSH);

endmodule

// ==== logic/if_id_reg.sv ====
/*
  IF-ID boundary. Data, error and PC registers only change on an accept, so
  they are frozen while ID stalls. Valid holds until explicitly cleared.
*/

`timescale 1ns/1ps

module if_id_reg (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           fetch_valid_i,
  input  if_pkg::instr_t fetch_rdata_i,
  input  if_pkg::addr_t  fetch_addr_i,
  input  logic           fetch_err_i,
  input  logic           id_in_ready_i,
  input  logic           pc_set_i,
  input  logic           instr_valid_clear_i,
  output logic           instr_accept_o,
  output logic           instr_valid_id_o,
  output logic           instr_new_id_o,
  output if_pkg::instr_t instr_rdata_id_o,
  output logic           instr_fetch_err_o,
  output if_pkg::addr_t  pc_id_o
);

  logic accept;
  logic valid_d, valid_q;
  logic new_q;

  // handshake between fetch output and ID
  assign accept         = fetch_valid_i & id_in_ready_i;
  assign instr_accept_o = accept;

  // a redirect in the accept cycle squashes the instruction
  // but new still pulses for that transfer
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  //////////////////////////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= accept;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  //////////////////////////////////////////////////////////////////////
  // pipeline registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      instr_fetch_err_o <= fetch_err_i;
      pc_id_o           <= fetch_addr_i;
    end
  end

endmodule

// ==== logic/if_pc_check.sv ====
/*
  Flags a fetch output whose PC is not the ID PC plus 4 while the stream is
  sequential. Any redirect ends the sequence until the next accept.
*/

`timescale 1ns/1ps
`include "if_config.svh"

module if_pc_check (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          pc_set_i,
  input  logic          instr_accept_i,
  input  logic          fetch_valid_i,
  input  if_pkg::addr_t fetch_addr_i,
  input  if_pkg::addr_t pc_id_i,
  output logic          pc_mismatch_alert_o
);

  logic          seq_q;
  if_pkg::addr_t pc_expected;

  // sequence starts with an accepted instruction, no check after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= (seq_q | instr_accept_i) & ~pc_set_i;
    end
  end

  assign pc_expected = pc_id_i + if_pkg::addr_t'(`IF_INSTR_BYTES);

  // only meaningful while fetch presents an item
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (fetch_addr_i != pc_expected);

endmodule

// ==== logic/if_pc_select.sv ====
/*
  Purely combinational. The boot address and mtvec lose their low 8 bits,
  and the selected PC always has its two low bits cleared.
*/

`timescale 1ns/1ps
`include "if_config.svh"

module if_pc_select (
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::irq_id_t     exc_cause_i,
  input  if_pkg::addr_t       boot_addr_i,
  input  if_pkg::addr_t       branch_target_ex_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  output if_pkg::addr_t       fetch_addr_n_o,
  output logic                csr_mtvec_init_o
);

  if_pkg::addr_t mtvec_base;
  if_pkg::addr_t boot_base;
  if_pkg::addr_t irq_offset;
  if_pkg::addr_t exc_pc;
  if_pkg::addr_t next_pc;

  // trap and boot bases, aligned to the vector table size
  assign mtvec_base = {csr_mtvec_i[31:`IF_VEC_ALIGN_BITS], {`IF_VEC_ALIGN_BITS{1'b0}}};
  assign boot_base  = {boot_addr_i[31:`IF_VEC_ALIGN_BITS], {`IF_VEC_ALIGN_BITS{1'b0}}};

  // one table entry per interrupt line, 4 bytes each
  assign irq_offset = {25'd0, exc_cause_i, 2'b00};

  // exception vector
  always_comb begin
    unique case (exc_pc_mux_i)
      if_pkg::EXC_PC_EXC:     exc_pc = mtvec_base;
      if_pkg::EXC_PC_IRQ:     exc_pc = mtvec_base + irq_offset;
      if_pkg::EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      if_pkg::EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:                exc_pc = mtvec_base;
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      if_pkg::PC_BOOT: next_pc = boot_base;
      if_pkg::PC_JUMP: next_pc = branch_target_ex_i;
      if_pkg::PC_EXC:  next_pc = exc_pc;
      if_pkg::PC_ERET: next_pc = csr_mepc_i;
      if_pkg::PC_DRET: next_pc = csr_depc_i;
      default:         next_pc = boot_base;
    endcase
  end

  // word alignment of every fetch
  assign fetch_addr_n_o = {next_pc[31:2], 2'b00};

  // CSR file loads mtvec from the boot address on a boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::PC_BOOT);

endmodule

// ==== logic/if_pkg.sv ====
/*
  Types shared by the fetch stage blocks. The enum encodings are not part of
  any external interface and may be changed together with their users.
*/

package if_pkg;

  //////////////////////////////////////////////////////////////////////
  // data widths
  //////////////////////////////////////////////////////////////////////

  // byte address of an instruction
  typedef logic [31:0] addr_t;
  // raw instruction word as read from the bus
  typedef logic [31:0] instr_t;
  // interrupt number for vectored mode
  typedef logic [4:0]  irq_id_t;

  //////////////////////////////////////////////////////////////////////
  // selectors and states
  //////////////////////////////////////////////////////////////////////

  // source of the next PC on a redirect
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception target within PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // fetch unit FSM
  typedef enum logic [2:0] {
    FETCH_IDLE  = 3'd0,
    FETCH_REQ   = 3'd1,
    FETCH_WAIT  = 3'd2,
    FETCH_FLUSH = 3'd3,
    FETCH_HOLD  = 3'd4
  } fetch_state_e;

endpackage

// ==== logic/if_stage.sv ====
/*
  Fetch stage top level. The boot address must be 256-byte aligned, only
  32-bit aligned instructions are supported, and nothing is fetched before
  the first pc_set_i.
*/

`timescale 1ns/1ps

module if_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  if_pkg::addr_t       boot_addr_i,
  // controller
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::irq_id_t     exc_cause_i,
  input  if_pkg::addr_t       branch_target_ex_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  // instruction bus
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::instr_t      instr_rdata_i,
  input  logic                instr_err_i,
  // towards ID
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output if_pkg::instr_t      instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output if_pkg::addr_t       pc_id_o,
  output if_pkg::addr_t       pc_if_o,
  // misc
  output logic                csr_mtvec_init_o,
  output logic                pc_mismatch_alert_o,
  output logic                if_busy_o
);

  if_pkg::addr_t  fetch_addr_n;
  logic           fetch_valid;
  if_pkg::instr_t fetch_rdata;
  if_pkg::addr_t  fetch_addr;
  logic           fetch_err;
  logic           instr_accept;

  // PC of the item waiting at the fetch output
  assign pc_if_o = fetch_addr;

  if_pc_select u_pc_select (
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_cause_i        (exc_cause_i),
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .fetch_addr_n_o     (fetch_addr_n),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  if_fetch_unit u_fetch_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pc_set_i       (pc_set_i),
    .fetch_addr_n_i (fetch_addr_n),
    .instr_accept_i (instr_accept),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .fetch_addr_o   (fetch_addr),
    .fetch_err_o    (fetch_err),
    .busy_o         (if_busy_o)
  );

  if_id_reg u_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (fetch_addr),
    .fetch_err_i         (fetch_err),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_accept_o      (instr_accept),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o)
  );

  if_pc_check u_pc_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pc_set_i            (pc_set_i),
    .instr_accept_i      (instr_accept),
    .fetch_valid_i       (fetch_valid),
    .fetch_addr_i        (fetch_addr),
    .pc_id_i             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule
